// File: compile.f
hdl/cpu_pkg.sv
hdl/register_file.sv
hdl/instruction_decoder.sv
hdl/hazard_control.sv
hdl/decode_execute_latch.sv
hdl/execute_unit.sv
hdl/decode_execute_core.sv
tests/core_assert.sv
tests/core_tb.sv

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // **************************************************
    // widths fixed by the instruction set
    // **************************************************
    localparam int data_width     = 16;
    localparam int reg_addr_width = 3;
    localparam int reg_sel_width  = 4;
    localparam int num_regs       = 8;

    // a write select of all ones means the instruction writes no register.
    // This keeps a bubble from looking like a write to r0.
    localparam logic [reg_sel_width-1:0] invalid_reg = '1;

    // opcode lives in instruction bits 15 to 12.
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_lli  = 4'd7,
        op_sll  = 4'd8,
        op_halt = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_shl,
        alu_pass_b
    } alu_op_e;

    // **************************************************
    // payloads
    // **************************************************
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [data_width-1:0]    read1_data;
        logic [data_width-1:0]    read2_data;
        logic [data_width-1:0]    imm_ext;
        logic                     alu_src;
        logic                     reg_write;
        logic [reg_sel_width-1:0] write_reg;
        logic                     halt;
    } de_payload_t;

    // the all-ones data fields make a bubble easy to spot in a waveform.
    localparam de_payload_t bubble_payload = '{
        alu_op:     alu_pass_b,
        read1_data: {data_width{1'b1}},
        read2_data: {data_width{1'b1}},
        imm_ext:    {data_width{1'b1}},
        alu_src:    1'b0,
        reg_write:  1'b0,
        write_reg:  invalid_reg,
        halt:       1'b0
    };

    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     data;
    } wb_t;

endpackage

// File: hdl/decode_execute_core.sv
`timescale 1ns/1ps

module decode_execute_core (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           instr_valid,
    input  logic [cpu_pkg::data_width-1:0] instr,
    output logic                           instr_ready,
    output cpu_pkg::wb_t                   wb,
    output logic                           halted
);
    import cpu_pkg::*;

    logic [reg_addr_width-1:0] rs_sel;
    logic [reg_addr_width-1:0] rt_sel;
    logic [data_width-1:0]     rs_data;
    logic [data_width-1:0]     rt_data;
    logic                      uses_rs;
    logic                      uses_rt;
    logic                      bubble;
    logic                      halt_seen;
    de_payload_t               payload_d;
    de_payload_t               payload_e;

    // **************************************************
    // decode stage
    // **************************************************
    register_file regs0 (
        .clk     (clk),
        .rst     (rst),
        .rs_sel  (rs_sel),
        .rt_sel  (rt_sel),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb      (wb)
    );

    instruction_decoder dec0 (
        .instr   (instr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rs_sel  (rs_sel),
        .rt_sel  (rt_sel),
        .uses_rs (uses_rs),
        .uses_rt (uses_rt),
        .payload (payload_d)
    );

    hazard_control hzd0 (
        .instr_valid  (instr_valid),
        .uses_rs      (uses_rs),
        .uses_rt      (uses_rt),
        .rs_sel       (rs_sel),
        .rt_sel       (rt_sel),
        .exec_payload (payload_e),
        .halt_seen    (halt_seen),
        .clk          (clk),
        .rst          (rst),
        .instr_ready  (instr_ready),
        .bubble       (bubble),
        .halted       (halted)
    );

    // **************************************************
    // execute stage
    // **************************************************
    decode_execute_latch de_latch0 (
        .clk       (clk),
        .rst       (rst),
        .bubble    (bubble),
        .payload_d (payload_d),
        .payload_e (payload_e)
    );

    execute_unit exe0 (
        .clk       (clk),
        .rst       (rst),
        .payload_e (payload_e),
        .wb        (wb),
        .halt_seen (halt_seen)
    );

endmodule

// File: hdl/decode_execute_latch.sv
`timescale 1ns/1ps

module decode_execute_latch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 bubble,
    input  cpu_pkg::de_payload_t payload_d,
    output cpu_pkg::de_payload_t payload_e
);
    import cpu_pkg::*;

    de_payload_t payload_next;

    // the bubble is picked in front of the register.
    // That way a stalled or empty decode slot never reaches execute.
    assign payload_next = bubble ? bubble_payload : payload_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            payload_e <= bubble_payload;
        end else begin
            payload_e <= payload_next;
        end
    end

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_pkg::de_payload_t payload_e,
    output cpu_pkg::wb_t         wb,
    output logic                 halt_seen
);
    import cpu_pkg::*;

    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] result;

    assign op_a = payload_e.read1_data;
    assign op_b = payload_e.alu_src ? payload_e.imm_ext : payload_e.read2_data;

    // **************************************************
    // ALU
    // **************************************************
    always_comb begin
        case (payload_e.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            // shift amount comes from the low four bits of the immediate.
            alu_shl:    result = op_a << op_b[3:0];
            alu_pass_b: result = op_b;
            default:    result = op_b;
        endcase
    end

    // **************************************************
    // writeback slot
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= payload_e.reg_write;
        end
        wb.dest <= payload_e.write_reg[reg_addr_width-1:0];
        wb.data <= result;
    end

    // hazard control sees the halt while it is still in execute.
    assign halt_seen = payload_e.halt;

endmodule

// File: hdl/hazard_control.sv
`timescale 1ns/1ps

module hazard_control (
    input  logic                               instr_valid,
    input  logic                               uses_rs,
    input  logic                               uses_rt,
    input  logic [cpu_pkg::reg_addr_width-1:0] rs_sel,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt_sel,
    input  cpu_pkg::de_payload_t               exec_payload,
    input  logic                               halt_seen,
    input  logic                               clk,
    input  logic                               rst,
    output logic                               instr_ready,
    output logic                               bubble,
    output logic                               halted
);
    import cpu_pkg::*;

    logic exec_writes;
    logic rs_hit;
    logic rt_hit;
    logic stall;
    logic stopping;

    // only a real write in execute can cause a hazard.
    // The invalid marker check keeps bubbles from matching r0.
    assign exec_writes = exec_payload.reg_write && (exec_payload.write_reg != invalid_reg);

    assign rs_hit = uses_rs && (exec_payload.write_reg == {1'b0, rs_sel});
    assign rt_hit = uses_rt && (exec_payload.write_reg == {1'b0, rt_sel});

    assign stall = instr_valid && exec_writes && (rs_hit || rt_hit);

    // nothing more is taken once a halt sits in execute, so no later
    // instruction can slip in behind it.
    assign stopping = halted || halt_seen;

    assign instr_ready = !stall && !stopping;
    assign bubble      = stall || !instr_valid || stopping;

    // halted is sticky until the next reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (halt_seen) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: hdl/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  logic [cpu_pkg::data_width-1:0]     instr,
    input  logic [cpu_pkg::data_width-1:0]     rs_data,
    input  logic [cpu_pkg::data_width-1:0]     rt_data,
    output logic [cpu_pkg::reg_addr_width-1:0] rs_sel,
    output logic [cpu_pkg::reg_addr_width-1:0] rt_sel,
    output logic                               uses_rs,
    output logic                               uses_rt,
    output cpu_pkg::de_payload_t               payload
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        imm_none,
        imm_sign6,
        imm_zero8,
        imm_zero4
    } imm_kind_e;

    opcode_e                   opcode;
    logic [reg_addr_width-1:0] rd_sel;
    imm_kind_e                 imm_kind;
    alu_op_e                   alu_op;
    logic                      alu_src;
    logic                      reg_write;
    logic [data_width-1:0]     imm_ext;

    assign opcode = opcode_e'(instr[15:12]);
    assign rd_sel = instr[11:9];
    assign rs_sel = instr[8:6];
    assign rt_sel = instr[5:3];

    // control fields; nop, halt and any undefined opcode keep the defaults.
    always_comb begin
        alu_src   = 1'b0;
        reg_write = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        imm_kind  = imm_none;
        case (opcode)
            op_add, op_sub, op_and, op_or, op_xor: begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            op_addi, op_sll: begin
                reg_write = 1'b1;
                uses_rs   = 1'b1;
                alu_src   = 1'b1;
                imm_kind  = (opcode == op_addi) ? imm_sign6 : imm_zero4;
            end
            op_lli: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_kind  = imm_zero8;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        case (opcode)
            op_add, op_addi: alu_op = alu_add;
            op_sub:          alu_op = alu_sub;
            op_and:          alu_op = alu_and;
            op_or:           alu_op = alu_or;
            op_xor:          alu_op = alu_xor;
            op_sll:          alu_op = alu_shl;
            default:         alu_op = alu_pass_b;
        endcase
    end

    always_comb begin
        case (imm_kind)
            imm_sign6: imm_ext = {{(data_width-6){instr[5]}}, instr[5:0]};
            imm_zero8: imm_ext = {{(data_width-8){1'b0}}, instr[7:0]};
            imm_zero4: imm_ext = {{(data_width-4){1'b0}}, instr[3:0]};
            default:   imm_ext = '0;
        endcase
    end

    assign payload.alu_op     = alu_op;
    assign payload.read1_data = rs_data;
    assign payload.read2_data = rt_data;
    assign payload.imm_ext    = imm_ext;
    assign payload.alu_src    = alu_src;
    assign payload.reg_write  = reg_write;
    assign payload.write_reg  = reg_write ? {1'b0, rd_sel} : invalid_reg;
    assign payload.halt       = (opcode == op_halt);

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [cpu_pkg::reg_addr_width-1:0] rs_sel,
    input  logic [cpu_pkg::reg_addr_width-1:0] rt_sel,
    output logic [cpu_pkg::data_width-1:0]     rs_data,
    output logic [cpu_pkg::data_width-1:0]     rt_data,
    input  cpu_pkg::wb_t                       wb
);
    import cpu_pkg::*;

    logic [data_width-1:0] regs [num_regs];
    logic                  rs_fwd;
    logic                  rt_fwd;

    // the write lands on the rising edge that ends the writeback cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // a read of the register being written in the same cycle sees the new value.
    // Because of this, decode only ever has to wait on the execute stage.
    assign rs_fwd = wb.valid && (wb.dest == rs_sel);
    assign rt_fwd = wb.valid && (wb.dest == rt_sel);

    assign rs_data = rs_fwd ? wb.data : regs[rs_sel];
    assign rt_data = rt_fwd ? wb.data : regs[rt_sel];

endmodule

// File: tests/core_assert.sv
`timescale 1ns/1ps

module core_assert_props (
    input logic         clk,
    input logic         rst,
    input logic         instr_ready,
    input cpu_pkg::wb_t wb,
    input logic         halted
);

    // the writeback slot is cleared by the reset edge itself.
    wb_quiet_in_reset: assert property (@(posedge clk) rst |=> !wb.valid)
        else $error("writeback valid right after a reset edge");

    // a halted core takes no more instructions.
    ready_low_when_halted: assert property (
        @(posedge clk) disable iff (rst) halted |-> !instr_ready)
        else $error("instr_ready high while halted");

    // the halt itself writes nothing, and nothing follows it into execute.
    no_wb_after_halt: assert property (
        @(posedge clk) disable iff (rst) $rose(halted) |-> ##2 !wb.valid)
        else $error("writeback valid two cycles after halted rose");

endmodule

bind decode_execute_core core_assert_props props0 (
    .clk         (clk),
    .rst         (rst),
    .instr_ready (instr_ready),
    .wb          (wb),
    .halted      (halted)
);

// File: tests/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import cpu_pkg::*;

    localparam int drive_delay  = 10;
    localparam int accept_limit = 20;
    localparam int halt_limit   = 20;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic [data_width-1:0] instr;
    logic                  instr_ready;
    wb_t                   wb;
    logic                  halted;

    logic [15:0] prog[$];
    string       exp_name[$];
    logic [2:0]  exp_reg[$];
    logic [15:0] exp_data[$];
    int          errors;
    int          wb_count;
    bit          file_ok;

    decode_execute_core dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb          (wb),
        .halted      (halted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // **************************************************
    // stimulus helpers
    // **************************************************
    task automatic load_testdata();
        int          fd;
        int          code;
        string       tag;
        string       name;
        string       rest;
        logic [15:0] word;
        logic [15:0] r;
        fd = $fopen("tests/core_testdata.txt", "r");
        file_ok = (fd != 0);
        if (!file_ok) begin
            $display("could not open tests/core_testdata.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "i") begin
                code = $fscanf(fd, "%h", word);
                prog.push_back(word);
            end else if (tag == "w") begin
                code = $fscanf(fd, "%s %h %h", name, r, word);
                exp_name.push_back(name);
                exp_reg.push_back(r[2:0]);
                exp_data.push_back(word);
            end else begin
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            #drive_delay;
        end
    endtask

    // instr_ready is sampled at the falling edge, where it has settled.
    task automatic send_instr(input logic [15:0] word);
        int waited;
        bit accepted;
        waited      = 0;
        accepted    = 1'b0;
        instr_valid = 1'b1;
        instr       = word;
        while (!accepted && waited < accept_limit) begin
            @(negedge clk);
            accepted = instr_ready;
            @(posedge clk);
            #drive_delay;
            waited++;
        end
        instr_valid = 1'b0;
        if (!accepted) begin
            $display("instruction %h was never accepted", word);
            errors++;
        end else if (waited > 2) begin
            $display("instruction %h stalled for more than one cycle", word);
            errors++;
        end
    endtask

    task automatic wait_halted();
        int waited;
        waited = 0;
        while (!halted && waited < halt_limit) begin
            @(posedge clk);
            #drive_delay;
            waited++;
        end
        if (!halted) begin
            $display("timed out waiting for halted after the halt instruction");
            errors++;
        end
    endtask

    task automatic offer_after_halt(input logic [15:0] word);
        instr_valid = 1'b1;
        instr       = word;
        repeat (4) begin
            @(negedge clk);
            if (instr_ready || !halted) begin
                $display("core was ready for instruction %h after halt", word);
                errors++;
            end
            @(posedge clk);
            #drive_delay;
        end
        instr_valid = 1'b0;
    endtask

    // **************************************************
    // writeback monitor
    // **************************************************
    always @(negedge clk) begin
        if (!rst && wb.valid) begin
            if (wb_count >= exp_data.size()) begin
                $display("unexpected writeback r%0d=%h beyond the expected sequence",
                         wb.dest, wb.data);
                errors++;
            end else if (wb.dest != exp_reg[wb_count] || wb.data != exp_data[wb_count]) begin
                $display("error %s: expected r%0d=%h, actual r%0d=%h", exp_name[wb_count],
                         exp_reg[wb_count], exp_data[wb_count], wb.dest, wb.data);
                errors++;
            end
            wb_count++;
        end
    end

    initial begin
        int seed_state;
        bit halt_sent;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        wb_count    = 0;
        halt_sent   = 1'b0;
        seed_state  = $urandom(32'h94e4_d66a);
        load_testdata();
        repeat (2) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        if (halted || !instr_ready || wb.valid) begin
            $display("core is not idle after reset");
            errors++;
        end
        if (file_ok) begin
            foreach (prog[n]) begin
                if (halt_sent) begin
                    offer_after_halt(prog[n]);
                end else begin
                    // even slots follow their predecessor directly, so dependent
                    // pairs there always meet the execute-stage hazard.
                    idle_cycles((n % 2 == 0) ? 0 : $urandom % 3);
                    send_instr(prog[n]);
                    if (prog[n][15:12] == 4'hf) begin
                        halt_sent = 1'b1;
                        wait_halted();
                    end
                end
            end
            idle_cycles(4);
            if (wb_count != exp_data.size()) begin
                $display("saw %0d writebacks where %0d were expected",
                         wb_count, exp_data.size());
                errors++;
            end
        end
        $display("errors: %0d, writebacks seen: %0d of %0d",
                 errors, wb_count, exp_data.size());
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tests/core_testdata.txt
# i <instruction hex>, offered in program order
# w <name> <dest register> <data hex>, expected writebacks in order
i 7205
w lli_r1 1 0005
i 740c
w lli_r2 2 000c
i 1650
w add_dep_rt 3 0011
i 28c8
w sub_dep_rs 4 000c
i 3ad0
w and_rr 5 0000
i 4c50
w or_rr 6 000d
i 5f30
w xor_dep_rt 7 0001
i 0000
i 627d
w addi_neg 1 0002
i 8444
w sll_dep 2 0020
i 9fff
i 70a5
w lli_r0 0 00a5
i 6601
w addi_r0 3 00a6
i 1800
w add_r0_r0 4 014a
i 6a9f
w addi_pos 5 003f
i 8d4f
w sll_dep_15 6 8000
i f000
i 7e55
